/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

  // Datapath sizing
  localparam int dataWidth = 16;
  localparam int imemAddrWidth = 8;

  // Opcode field, instr[15:12]
  typedef enum logic [3:0] {
    ADD    = 4'b0000,
    SUB    = 4'b0001,
    RED    = 4'b0010,
    XOR    = 4'b0011,
    SLL    = 4'b0100,
    SRA    = 4'b0101,
    ROR    = 4'b0110,
    PADDSB = 4'b0111,
    LW     = 4'b1000,
    SW     = 4'b1001,
    LHB    = 4'b1010,
    LLB    = 4'b1011,
    B      = 4'b1100,
    BR     = 4'b1101,
    PCS    = 4'b1110,
    HLT    = 4'b1111
  } opcodeE;

  // Which immediate field the instruction carries
  typedef enum logic [1:0] {
    imm4 = 2'b00,
    imm8 = 2'b01,
    imm9 = 2'b10
  } immSizeE;

  // Branch condition, instr[11:9]
  typedef enum logic [2:0] {
    NE = 3'b000,
    EQ = 3'b001,
    GT = 3'b010,
    LT = 3'b011,
    GE = 3'b100,
    LE = 3'b101,
    OV = 3'b110,
    AL = 3'b111
  } condE;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flagsT;

  // Decoded control word
  typedef struct packed {
    logic    regDest;
    logic    readDest;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    memToReg;
    logic    aluSrc;
    opcodeE  aluOp;
    immSizeE immSize;
    logic    branch;
    logic    branchSrc;
    logic    pcSave;
    logic    halt;
    logic    setZ;
    logic    setV;
    logic    setN;
  } ctrlT;

endpackage

`default_nettype wire

/* memBusIf.sv */
`default_nettype none

// Data-memory request between the core and the load/store unit
interface memBusIf import cpuPkg::*; ();
  logic                 valid;
  logic                 ready;
  logic                 write;
  logic [dataWidth-1:0] addr;
  logic [dataWidth-1:0] wdata;
  logic [dataWidth-1:0] rdata;
  logic                 done;

  // Core side issues, unit side answers
  modport core (output valid, write, addr, wdata, input ready, rdata, done);
  modport lsu (input valid, write, addr, wdata, output ready, rdata, done);

endinterface

`default_nettype wire

/* control.sv */
`default_nettype none

module control import cpuPkg::*; (
  input  opcodeE op,
  output ctrlT   ctrl
);

  // Slot layout from the top nibble down
  //   arith  op rd rs rt
  //   shift  op rd rs imm4
  //   lw/sw  op rt rs off4
  //   lhb    op rd imm8
  //   b      op cond+imm9
  //   br     op cond rs x
  //   pcs    op rd x x

  always_comb begin
    ctrl = '0;
    ctrl.aluOp = op;
    // Branch offset is the default immediate
    ctrl.immSize = imm9;
    // Opcodes 0-7 all write rd
    ctrl.regWrite = !op[3];
    case (op)
      ADD, SUB: begin
        ctrl.setZ = 1'b1;
        ctrl.setV = 1'b1;
        ctrl.setN = 1'b1;
      end
      XOR: ctrl.setZ = 1'b1;
      SLL, SRA, ROR: begin
        // Shift amount from slot 3
        ctrl.aluSrc = 1'b1;
        ctrl.immSize = imm4;
        ctrl.setZ = 1'b1;
      end
      LW: begin
        ctrl.regWrite = 1'b1;
        ctrl.memRead = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.immSize = imm4;
      end
      SW: begin
        // Store data register sits in slot 1
        ctrl.regDest = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.immSize = imm4;
      end
      LHB, LLB: begin
        // rd is also the source for byte merge
        ctrl.readDest = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.immSize = imm8;
      end
      B: ctrl.branch = 1'b1;
      BR: begin
        ctrl.branch = 1'b1;
        ctrl.branchSrc = 1'b1;
      end
      PCS: begin
        ctrl.regWrite = 1'b1;
        ctrl.pcSave = 1'b1;
      end
      HLT: ctrl.halt = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile import cpuPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [3:0]           readAddr1,
  input  logic [3:0]           readAddr2,
  input  logic [3:0]           writeAddr,
  input  logic                 writeEn,
  input  logic [dataWidth-1:0] writeData,
  output logic [dataWidth-1:0] readData1,
  output logic [dataWidth-1:0] readData2
);

  logic [dataWidth-1:0] regs [16];

  // Register 0 never takes a write
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && writeAddr != 4'd0) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Combinational reads, old value until the edge
  assign readData1 = (readAddr1 == 4'd0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == 4'd0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu import cpuPkg::*; (
  input  opcodeE               aluOp,
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  logic [7:0]           imm8,
  output logic [dataWidth-1:0] result,
  output flagsT                flagsOut
);

  // Signed nibble add clamped to -8..7
  function automatic logic [3:0] satAdd4(input logic [3:0] x, input logic [3:0] y);
    logic [3:0] s;
    s = x + y;
    if (x[3] == y[3] && s[3] != x[3]) begin
      satAdd4 = x[3] ? 4'h8 : 4'h7;
    end else begin
      satAdd4 = s;
    end
  endfunction

  logic [dataWidth-1:0] sum;
  logic [dataWidth-1:0] diff;
  logic                 addOvf;
  logic                 subOvf;
  logic signed [9:0]    redSum;
  logic [3:0]           shamt;
  logic [2*dataWidth-1:0] rotWord;
  logic                 vFlag;

  assign sum = a + b;
  assign diff = a - b;
  // Overflow when result sign disagrees with operand signs
  assign addOvf = (a[15] == b[15]) && (sum[15] != a[15]);
  assign subOvf = (a[15] != b[15]) && (diff[15] != a[15]);

  // Four signed bytes, worst case fits in 10 bits
  assign redSum = $signed({{2{a[15]}}, a[15:8]}) + $signed({{2{a[7]}}, a[7:0]})
                + $signed({{2{b[15]}}, b[15:8]}) + $signed({{2{b[7]}}, b[7:0]});

  assign shamt = b[3:0];
  assign rotWord = {a, a} >> shamt;

  always_comb begin
    vFlag = 1'b0;
    case (aluOp)
      ADD: begin
        result = addOvf ? (a[15] ? 16'h8000 : 16'h7fff) : sum;
        vFlag = addOvf;
      end
      SUB: begin
        result = subOvf ? (a[15] ? 16'h8000 : 16'h7fff) : diff;
        vFlag = subOvf;
      end
      RED: result = {{6{redSum[9]}}, redSum};
      XOR: result = a ^ b;
      SLL: result = a << shamt;
      SRA: result = $signed(a) >>> shamt;
      ROR: result = rotWord[dataWidth-1:0];
      PADDSB: begin
        result = {satAdd4(a[15:12], b[15:12]), satAdd4(a[11:8], b[11:8]),
                  satAdd4(a[7:4], b[7:4]), satAdd4(a[3:0], b[3:0])};
      end
      // Address generation
      LW, SW: result = sum;
      LHB: result = {imm8, a[7:0]};
      LLB: result = {a[15:8], imm8};
      default: result = a;
    endcase
  end

  assign flagsOut.z = (result == '0);
  assign flagsOut.v = vFlag;
  assign flagsOut.n = result[15];

endmodule

`default_nettype wire

/* pcUnit.sv */
`default_nettype none

module pcUnit import cpuPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 advance,
  input  ctrlT                 ctrl,
  input  condE                 cond,
  input  logic [8:0]           imm9,
  input  logic [dataWidth-1:0] regTarget,
  input  flagsT                flagsIn,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] pcPlus2,
  output logic                 halted
);

  flagsT                flags;
  logic                 condMet;
  logic                 taken;
  logic [dataWidth-1:0] target;

  // Condition tested on flags from earlier instructions
  always_comb begin
    case (cond)
      NE: condMet = !flags.z;
      EQ: condMet = flags.z;
      GT: condMet = !flags.z && !flags.n;
      LT: condMet = flags.n;
      GE: condMet = flags.z || !flags.n;
      LE: condMet = flags.n || flags.z;
      OV: condMet = flags.v;
      default: condMet = 1'b1;
    endcase
  end

  assign pcPlus2 = pc + 16'd2;
  // B offset counts words from PC+2
  assign target = ctrl.branchSrc ? regTarget : pcPlus2 + {{6{imm9[8]}}, imm9, 1'b0};
  assign taken = ctrl.branch && condMet;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
      flags <= '0;
      halted <= 1'b0;
    end else if (advance && !halted) begin
      if (ctrl.halt) begin
        // PC stays on the HLT
        halted <= 1'b1;
      end else begin
        pc <= taken ? target : pcPlus2;
      end
      if (ctrl.setZ) flags.z <= flagsIn.z;
      if (ctrl.setV) flags.v <= flagsIn.v;
      if (ctrl.setN) flags.n <= flagsIn.n;
    end
  end

  // Catches a BR to an odd register value
  assert property (@(posedge clk) disable iff (!rstN) !pc[0])
    else $error("pcUnit: odd pc %h", pc);

endmodule

`default_nettype wire

/* loadStore.sv */
`default_nettype none

module loadStore import cpuPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  memBusIf.lsu                 bus,
  output logic                 memValid,
  output logic                 memWrite,
  output logic [dataWidth-1:0] memAddr,
  output logic [dataWidth-1:0] memWdata,
  input  logic                 memReady,
  input  logic [dataWidth-1:0] memRdata
);

  logic                 doneQ;
  logic [dataWidth-1:0] rdataQ;

  // Idle and past the done cycle in which the core still shows the finished op
  assign bus.ready = !memValid && !doneQ;
  assign bus.done = doneQ;
  assign bus.rdata = rdataQ;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memValid <= 1'b0;
      doneQ <= 1'b0;
    end else begin
      doneQ <= memValid && memReady;
      if (bus.valid && bus.ready) begin
        memValid <= 1'b1;
      end else if (memReady) begin
        memValid <= 1'b0;
      end
    end
  end

  // Request payload and load data
  always_ff @(posedge clk) begin
    if (bus.valid && bus.ready) begin
      memWrite <= bus.write;
      memAddr <= bus.addr;
      memWdata <= bus.wdata;
    end
    if (memValid && memReady) begin
      rdataQ <= memRdata;
    end
  end

  // While a request is held the core keeps presenting the same access
  assert property (@(posedge clk) disable iff (!rstN)
    memValid |-> bus.valid && bus.write == memWrite && bus.addr == memAddr
      && bus.wdata == memWdata)
    else $error("loadStore: core request changed while held");

endmodule

`default_nettype wire

/* instrMem.sv */
`default_nettype none

module instrMem import cpuPkg::*; (
  input  logic                     clk,
  input  logic                     progWe,
  input  logic [imemAddrWidth-1:0] progAddr,
  input  logic [dataWidth-1:0]     progData,
  input  logic [imemAddrWidth-1:0] fetchAddr,
  output logic [dataWidth-1:0]     instr
);

  logic [dataWidth-1:0] mem [2**imemAddrWidth];

  // Program load port
  always_ff @(posedge clk) begin
    if (progWe) begin
      mem[progAddr] <= progData;
    end
  end

  // Fetch in the same cycle
  assign instr = mem[fetchAddr];

endmodule

`default_nettype wire

/* cpuTop.sv */
`default_nettype none

module cpuTop import cpuPkg::*; (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     enable,
  input  logic                     progWe,
  input  logic [imemAddrWidth-1:0] progAddr,
  input  logic [dataWidth-1:0]     progData,
  output logic                     memValid,
  output logic                     memWrite,
  output logic [dataWidth-1:0]     memAddr,
  output logic [dataWidth-1:0]     memWdata,
  input  logic                     memReady,
  input  logic [dataWidth-1:0]     memRdata,
  output logic                     halted
);

  logic [dataWidth-1:0] instr, pc, pcPlus2;
  logic [dataWidth-1:0] readData1, readData2, writeData;
  logic [dataWidth-1:0] immExt, imm4Ext, aluB, aluResult;
  logic [3:0]           readAddr1, readAddr2;
  logic                 isMem, advance;
  ctrlT                 ctrl;
  flagsT                aluFlags;

  memBusIf memBus ();

  control uControl (.op(opcodeE'(instr[15:12])), .ctrl(ctrl));

  // Slot 2 is rs, slot 3 rt, slot 1 rd
  assign readAddr1 = ctrl.readDest ? instr[11:8] : instr[7:4];
  assign readAddr2 = ctrl.regDest ? instr[11:8] : instr[3:0];

  // Memory offset is signed words, shift amount unsigned
  assign imm4Ext = isMem ? {{11{instr[3]}}, instr[3:0], 1'b0} : {12'd0, instr[3:0]};
  assign immExt = (ctrl.immSize == imm4) ? imm4Ext :
                  (ctrl.immSize == imm8) ? {8'd0, instr[7:0]} :
                  {{7{instr[8]}}, instr[8:0]};
  assign aluB = ctrl.aluSrc ? immExt : readData2;

  // Memory ops wait for done, everything else one cycle
  assign isMem = ctrl.memRead || ctrl.memWrite;
  assign advance = enable && !halted && (!isMem || memBus.done);

  assign writeData = ctrl.pcSave ? pcPlus2 : ctrl.memToReg ? memBus.rdata : aluResult;

  assign memBus.valid = isMem && enable && !halted;
  assign memBus.write = ctrl.memWrite;
  assign memBus.addr = aluResult;
  assign memBus.wdata = readData2;

  regFile uRegFile (
    .clk(clk), .rstN(rstN), .readAddr1(readAddr1), .readAddr2(readAddr2),
    .writeAddr(instr[11:8]), .writeEn(ctrl.regWrite && advance), .writeData(writeData),
    .readData1(readData1), .readData2(readData2)
  );

  alu uAlu (
    .aluOp(ctrl.aluOp), .a(readData1), .b(aluB), .imm8(instr[7:0]),
    .result(aluResult), .flagsOut(aluFlags)
  );

  pcUnit uPcUnit (
    .clk(clk), .rstN(rstN), .advance(advance), .ctrl(ctrl), .cond(condE'(instr[11:9])),
    .imm9(instr[8:0]), .regTarget(readData1), .flagsIn(aluFlags),
    .pc(pc), .pcPlus2(pcPlus2), .halted(halted)
  );

  loadStore uLoadStore (
    .clk(clk), .rstN(rstN), .bus(memBus), .memValid(memValid), .memWrite(memWrite),
    .memAddr(memAddr), .memWdata(memWdata), .memReady(memReady), .memRdata(memRdata)
  );

  // Word fetch from byte PC
  instrMem uInstrMem (
    .clk(clk), .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .fetchAddr(pc[8:1]), .instr(instr)
  );

endmodule

`default_nettype wire

/* cpuTb.sv */
`default_nettype none

module cpuTb import cpuPkg::*; ();

  logic                     clk;
  logic                     rstN;
  logic                     enable;
  logic                     progWe;
  logic [imemAddrWidth-1:0] progAddr;
  logic [dataWidth-1:0]     progData;
  logic                     memValid;
  logic                     memWrite;
  logic [dataWidth-1:0]     memAddr;
  logic [dataWidth-1:0]     memWdata;
  logic                     memReady;
  logic [dataWidth-1:0]     memRdata;
  logic                     halted;

  // Program being built and the stores it should produce
  logic [15:0] prog [$];
  logic [15:0] expAddr [$];
  logic [15:0] expData [$];
  // Stores seen on the port, in order
  logic [15:0] storeAddrQ [$];
  logic [15:0] storeDataQ [$];
  logic [15:0] dataMem [32768];
  integer      seed;
  int          delay;
  bit          armed;
  int          errors;

  cpuTop uut (
    .clk(clk), .rstN(rstN), .enable(enable), .progWe(progWe), .progAddr(progAddr),
    .progData(progData), .memValid(memValid), .memWrite(memWrite), .memAddr(memAddr),
    .memWdata(memWdata), .memReady(memReady), .memRdata(memRdata), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Data memory with 0-3 cycle ready delay
  initial begin
    memReady = 1'b0;
    memRdata = '0;
    seed = 32'h13ff0dad;
    armed = 1'b0;
    delay = 0;
    for (int i = 0; i < 32768; i++) begin
      dataMem[i] = 16'(i) ^ 16'ha5c3;
    end
    forever begin
      @(posedge clk);
      if (!rstN) begin
        memReady <= 1'b0;
        armed = 1'b0;
      end else if (memValid && memReady) begin
        // Transfer on this edge
        if (memWrite) begin
          dataMem[memAddr[15:1]] = memWdata;
          storeAddrQ.push_back(memAddr);
          storeDataQ.push_back(memWdata);
        end
        memReady <= 1'b0;
        armed = 1'b0;
      end else if (memValid) begin
        if (!armed) begin
          armed = 1'b1;
          delay = $random(seed) & 3;
        end
        if (delay == 0) begin
          memReady <= 1'b1;
          memRdata <= dataMem[memAddr[15:1]];
        end else begin
          delay--;
        end
      end
    end
  end

  // Instruction encoders
  function automatic logic [15:0] instrWord(input opcodeE op, input int a, input int b,
                                            input int c);
    return {op, 4'(a), 4'(b), 4'(c)};
  endfunction

  function automatic logic [15:0] byteInstr(input opcodeE op, input int rd,
                                            input logic [7:0] imm);
    return {op, 4'(rd), imm};
  endfunction

  function automatic logic [15:0] branchInstr(input condE c, input int off);
    return {B, c, 9'(off)};
  endfunction

  function automatic logic [15:0] regBranch(input condE c, input int rs);
    return {BR, c, 1'b0, 4'(rs), 4'd0};
  endfunction

  // Saturating add or subtract, bit 16 flags saturation
  function automatic logic [16:0] addSubRef(input logic [15:0] x, input logic [15:0] y,
                                            input bit sub);
    int s;
    if (sub) begin
      s = int'($signed(x)) - int'($signed(y));
    end else begin
      s = int'($signed(x)) + int'($signed(y));
    end
    if (s > 32767) begin
      return {1'b1, 16'h7fff};
    end else if (s < -32768) begin
      return {1'b1, 16'h8000};
    end
    return {1'b0, 16'(s)};
  endfunction

  function automatic logic [15:0] paddsbRef(input logic [15:0] x, input logic [15:0] y);
    logic [15:0] r;
    int          s;
    for (int i = 0; i < 4; i++) begin
      s = int'($signed(x[4*i +: 4])) + int'($signed(y[4*i +: 4]));
      // Each lane clamps to -8..7
      if (s > 7) begin
        s = 7;
      end else if (s < -8) begin
        s = -8;
      end
      r[4*i +: 4] = 4'(s);
    end
    return r;
  endfunction

  function automatic logic [15:0] redRef(input logic [15:0] x, input logic [15:0] y);
    int s;
    s = int'($signed(x[15:8])) + int'($signed(x[7:0]))
      + int'($signed(y[15:8])) + int'($signed(y[7:0]));
    return 16'(s);
  endfunction

  // One bit position per step
  function automatic logic [15:0] shiftRef(input opcodeE op, input logic [15:0] x, input int n);
    logic [15:0] r;
    r = x;
    for (int i = 0; i < n; i++) begin
      case (op)
        SLL: r = {r[14:0], 1'b0};
        SRA: r = {r[15], r[15:1]};
        default: r = {r[0], r[15:1]};
      endcase
    end
    return r;
  endfunction

  function automatic bit condRef(input condE c, input bit z, input bit v, input bit n);
    case (c)
      NE: return !z;
      EQ: return z;
      GT: return !z && !n;
      LT: return n;
      GE: return z || !n;
      LE: return n || z;
      OV: return v;
      default: return 1'b1;
    endcase
  endfunction

  task automatic startProgram();
    prog.delete();
    expAddr.delete();
    expData.delete();
  endtask

  // LLB keeps the high byte, so LHB comes second
  task automatic loadConst(input int rd, input logic [15:0] value);
    prog.push_back(byteInstr(LLB, rd, value[7:0]));
    prog.push_back(byteInstr(LHB, rd, value[15:8]));
  endtask

  task automatic storeReg(input int rt, input int rs, input int off);
    prog.push_back(instrWord(SW, rt, rs, off));
  endtask

  task automatic expectStore(input logic [15:0] addr, input logic [15:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // Load with enable low, reset, then run until halted
  task automatic runProgram(input string name);
    int cycles;
    prog.push_back(instrWord(HLT, 0, 0, 0));
    @(posedge clk);
    enable <= 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      progWe <= 1'b1;
      progAddr <= 8'(i);
      progData <= prog[i];
    end
    @(posedge clk);
    progWe <= 1'b0;
    storeAddrQ.delete();
    storeDataQ.delete();
    rstN <= 1'b0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    enable <= 1'b1;
    cycles = 0;
    while (!halted && cycles < 5000) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("%s: the core did not halt within %0d cycles", name, cycles);
      errors++;
    end
  endtask

  task automatic checkStores(input string name);
    if (storeAddrQ.size() != expAddr.size()) begin
      $display("[ERROR] %0t %s: %0d stores seen, %0d expected", $time, name,
               storeAddrQ.size(), expAddr.size());
      errors++;
    end else begin
      for (int i = 0; i < expAddr.size(); i++) begin
        if (storeAddrQ[i] !== expAddr[i] || storeDataQ[i] !== expData[i]) begin
          $display("[ERROR] %0t %s: store %0d got %h <= %h, expected %h <= %h", $time, name,
                   i, storeAddrQ[i], storeDataQ[i], expAddr[i], expData[i]);
          errors++;
        end
      end
    end
  endtask

  task automatic arithTest();
    logic [15:0] want [6];
    int          src [6] = '{3, 6, 7, 9, 10, 11};
    startProgram();
    loadConst(1, 16'h7000);
    loadConst(2, 16'h2000);
    loadConst(4, 16'h1234);
    loadConst(5, 16'h0111);
    loadConst(8, 16'h8100);
    loadConst(12, 16'h7f88);
    loadConst(15, 16'h0100);
    // Positive saturation, plain add, plain sub, negative saturation
    prog.push_back(instrWord(ADD, 3, 1, 2));
    prog.push_back(instrWord(ADD, 6, 4, 5));
    prog.push_back(instrWord(SUB, 7, 1, 2));
    prog.push_back(instrWord(SUB, 9, 8, 1));
    prog.push_back(instrWord(RED, 10, 4, 8));
    prog.push_back(instrWord(PADDSB, 11, 4, 12));
    want[0] = 16'(addSubRef(16'h7000, 16'h2000, 1'b0));
    want[1] = 16'(addSubRef(16'h1234, 16'h0111, 1'b0));
    want[2] = 16'(addSubRef(16'h7000, 16'h2000, 1'b1));
    want[3] = 16'(addSubRef(16'h8100, 16'h7000, 1'b1));
    want[4] = redRef(16'h1234, 16'h8100);
    want[5] = paddsbRef(16'h1234, 16'h7f88);
    for (int i = 0; i < 6; i++) begin
      storeReg(src[i], 15, i);
      expectStore(16'(16'h0100 + 2 * i), want[i]);
    end
    runProgram("arith");
    checkStores("arith");
  endtask

  task automatic logicTest();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] want [8];
    a = 16'ha5f0;
    b = 16'h0ff3;
    startProgram();
    loadConst(1, a);
    loadConst(2, b);
    loadConst(15, 16'h0190);
    prog.push_back(instrWord(XOR, 3, 1, 2));
    prog.push_back(instrWord(SLL, 4, 1, 3));
    prog.push_back(instrWord(SRA, 5, 1, 5));
    prog.push_back(instrWord(ROR, 6, 1, 7));
    prog.push_back(instrWord(SRA, 7, 1, 15));
    prog.push_back(instrWord(ROR, 8, 2, 0));
    prog.push_back(instrWord(SLL, 9, 2, 12));
    prog.push_back(instrWord(ROR, 10, 2, 9));
    want[0] = a ^ b;
    want[1] = shiftRef(SLL, a, 3);
    want[2] = shiftRef(SRA, a, 5);
    want[3] = shiftRef(ROR, a, 7);
    want[4] = shiftRef(SRA, a, 15);
    want[5] = shiftRef(ROR, b, 0);
    want[6] = shiftRef(SLL, b, 12);
    want[7] = shiftRef(ROR, b, 9);
    // Offsets -4..3 around the base
    for (int i = 0; i < 8; i++) begin
      storeReg(i + 3, 15, i - 4);
      expectStore(16'(16'h0190 + 2 * (i - 4)), want[i]);
    end
    runProgram("logic");
    checkStores("logic");
  endtask

  task automatic memoryTest();
    logic [15:0] sum;
    sum = 16'(addSubRef(16'h3456, 16'h3456, 1'b0));
    startProgram();
    loadConst(1, 16'h3456);
    loadConst(2, 16'h0200);
    loadConst(3, 16'h0210);
    storeReg(1, 2, 3);
    // Same word reached from the other base
    prog.push_back(instrWord(LW, 4, 3, -5));
    storeReg(4, 2, 7);
    prog.push_back(instrWord(ADD, 5, 4, 1));
    storeReg(5, 3, -8);
    prog.push_back(instrWord(LW, 6, 2, 0));
    storeReg(6, 3, 1);
    expectStore(16'h0206, 16'h3456);
    expectStore(16'h020e, 16'h3456);
    expectStore(16'h0200, sum);
    expectStore(16'h0212, sum);
    runProgram("memory");
    checkStores("memory");
  endtask

  task automatic branchTest();
    logic [15:0] regVal [5] = '{16'h0000, 16'h0005, 16'h0005, 16'h7000, 16'hfff0};
    opcodeE      setOp [5] = '{SUB, ADD, ADD, XOR, ADD};
    int          setA [5] = '{1, 1, 4, 1, 3};
    int          setB [5] = '{2, 2, 1, 2, 3};
    logic [16:0] r;
    bit          fz;
    bit          fv;
    bit          fn;
    int          k;
    startProgram();
    for (int i = 1; i < 5; i++) begin
      loadConst(i, regVal[i]);
    end
    loadConst(7, 16'h00aa);
    loadConst(8, 16'h0300);
    fz = 1'b0;
    fv = 1'b0;
    fn = 1'b0;
    k = 0;
    // Zero, positive, negative, z with n held, overflow
    for (int c = 0; c < 8; c++) begin
      for (int s = 0; s < 5; s++) begin
        prog.push_back(instrWord(setOp[s], 6, setA[s], setB[s]));
        if (setOp[s] == XOR) begin
          fz = (regVal[setA[s]] ^ regVal[setB[s]]) == 16'd0;
        end else begin
          r = addSubRef(regVal[setA[s]], regVal[setB[s]], setOp[s] == SUB);
          fz = r[15:0] == 16'd0;
          fv = r[16];
          fn = r[15];
        end
        // Marker address per case, LLB leaves flags alone
        prog.push_back(byteInstr(LLB, 8, 8'(2 * k)));
        prog.push_back(branchInstr(condE'(3'(c)), 1));
        storeReg(7, 8, 0);
        if (!condRef(condE'(3'(c)), fz, fv, fn)) begin
          expectStore(16'(16'h0300 + 2 * k), 16'h00aa);
        end
        k++;
      end
    end
    runProgram("branch");
    checkStores("branch");
  endtask

  task automatic callHaltTest();
    int pcsAddr;
    int seen;
    startProgram();
    loadConst(2, 16'h0400);
    loadConst(4, 16'h0002);
    pcsAddr = 2 * prog.size();
    prog.push_back(instrWord(PCS, 3, 0, 0));
    // Skip return point, HLT and trap to reach the routine
    prog.push_back(branchInstr(AL, 3));
    storeReg(6, 2, 1);
    prog.push_back(instrWord(HLT, 0, 0, 0));
    storeReg(9, 2, 7);
    storeReg(3, 2, 0);
    prog.push_back(byteInstr(LLB, 6, 8'h5a));
    // Return past the branch that made the call
    prog.push_back(instrWord(ADD, 3, 3, 4));
    prog.push_back(regBranch(AL, 3));
    expectStore(16'h0400, 16'(pcsAddr + 2));
    expectStore(16'h0402, 16'h005a);
    runProgram("call");
    checkStores("call");
    seen = storeAddrQ.size();
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      if (!halted) begin
        $display("[ERROR] %0t call: halted dropped after HLT", $time);
        errors++;
      end
    end
    if (storeAddrQ.size() != seen) begin
      $display("[ERROR] %0t call: %0d stores after halt", $time, storeAddrQ.size() - seen);
      errors++;
    end
  endtask

  initial begin
    rstN = 1'b0;
    enable = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    errors = 0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    arithTest();
    logicTest();
    memoryTest();
    branchTest();
    callHaltTest();
    $display("Tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
cpuPkg.sv
memBusIf.sv
control.sv
regFile.sv
alu.sv
pcUnit.sv
loadStore.sv
instrMem.sv
cpuTop.sv
cpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpuTb simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuTb -f project.f -o cpuSim
./obj_dir/cpuSim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
